/* Makefile */
# Verilator build and run for the commit subsystem testbench

TOP    ?= commit_subsystem_tb
LOG    ?= sim.log
FLIST  ?= list.f
VFLAGS ?= --timing
OBJ    ?= obj_dir

BIN     := $(OBJ)/V$(TOP)
SOURCES := $(wildcard design/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	verilator --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ) \
	  -o V$(TOP) -f $(FLIST)

# the log decides pass or fail, not the exit code of the binary
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test passed" $(LOG); then \
	  echo "simulation PASS"; \
	else \
	  echo "simulation FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)

/* design/branch_history_table.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch history table
// direct-mapped 2-bit saturating counters, trained at commit and read by pc
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module branch_history_table (
  input  logic                              CLK,
  input  logic                              nRST,
  input  commit_types_pkg::predict_update_t predict_upd,
  input  rv32_types_pkg::pc_t               lookup_pc,
  output logic                              predict_taken
);

  import commit_types_pkg::*;

  logic [1:0]           counters [BHT_ENTRIES]; // one counter per index
  logic [BHT_IDX_W-1:0] upd_idx;
  logic [BHT_IDX_W-1:0] look_idx;
  logic [1:0]           upd_ctr;                // counter being trained

  // index from pc[5:2]
  assign upd_idx  = predict_upd.update_addr[BHT_IDX_LSB +: BHT_IDX_W];
  assign look_idx = lookup_pc[BHT_IDX_LSB +: BHT_IDX_W];
  assign upd_ctr  = counters[upd_idx];

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        counters[i] <= CTR_WEAK_NT;  // all weakly not-taken
      end
    end else if (predict_upd.update_predictor) begin
      if (predict_upd.branch_result) begin
        if (upd_ctr != CTR_MAX)
          counters[upd_idx] <= upd_ctr + 2'b01;  // toward taken
      end else begin
        if (upd_ctr != CTR_MIN)
          counters[upd_idx] <= upd_ctr - 2'b01;  // toward not-taken
      end
    end
  end

  // msb of the counter is the direction
  // an update at an edge shows here from the next cycle
  assign predict_taken = counters[look_idx][1];

endmodule

`default_nettype wire

/* design/commit_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Commit stage
// retires the done head entry when not stalled; derives predictor update,
// fault report and mispredict flag, and tracks the latest valid pc
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module commit_stage (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic                              halt,
  input  logic                              stall,       // inverse of pc_en
  // head of the completion buffer
  input  logic                              head_valid,
  input  commit_types_pkg::commit_rec_t     head,
  output logic                              pop,
  // retirement results
  output logic                              retire,
  output rv32_types_pkg::pc_t               retire_pc,
  output commit_types_pkg::predict_update_t predict_upd,
  output commit_types_pkg::fault_rep_t      fault,
  output logic                              mispredict,
  output rv32_types_pkg::pc_t               latest_valid_pc
);

  import rv32_types_pkg::*;
  import commit_types_pkg::*;

  logic retire_br;   // a branch retires this cycle
  logic real_insn;   // head is not a bubble

  // one retire per cycle, same-cycle pop back to the buffer
  assign pop       = head_valid & ~stall;
  assign retire    = pop;
  assign retire_pc = head.pc;

  assign retire_br = retire & head.branch_instr;
  assign real_insn = (head.opcode != OPC_BUBBLE);

  // predictor training, indexed by the branch pc itself
  assign predict_upd.update_predictor = retire_br;
  assign predict_upd.update_addr      = head.pc;
  assign predict_upd.branch_result    = head.branch_taken;
  assign predict_upd.prediction       = head.prediction;

  // flag only, no flush on this path
  assign mispredict = retire_br & (head.prediction != head.branch_taken);

  // instruction fault, badaddr is the pc of the faulting insn
  assign fault.fault_insn = retire & head.fault_insn;
  assign fault.badaddr_i  = head.pc;

  // latest valid pc
  // halt wins over a retire in the same cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      latest_valid_pc <= '0;
    end else if (halt) begin
      latest_valid_pc <= '0;
    end else if (retire & real_insn) begin
      latest_valid_pc <= head.pc;  // bubbles leave it alone
    end
  end

endmodule

`default_nettype wire

/* design/commit_subsystem.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Commit subsystem
// completion buffer, commit stage and branch history table joined together
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module commit_subsystem (
  input  logic                            CLK,
  input  logic                            nRST,
  // dispatch
  input  logic                            alloc,
  input  commit_types_pkg::dispatch_rec_t alloc_rec,
  output logic                            full,
  output commit_types_pkg::cb_tag_t       alloc_tag,
  // writeback
  input  logic                            wb_valid,
  input  commit_types_pkg::wb_rec_t       wb_rec,
  // hazard side
  input  logic                            stall,
  input  logic                            halt,
  // retirement
  output logic                            retire,
  output rv32_types_pkg::pc_t             retire_pc,
  output commit_types_pkg::fault_rep_t    fault,
  output logic                            mispredict,
  output rv32_types_pkg::pc_t             latest_valid_pc,
  // prediction lookup
  input  rv32_types_pkg::pc_t             lookup_pc,
  output logic                            predict_taken
);

  import commit_types_pkg::*;

  logic            head_valid;  // head slot done
  commit_rec_t     head;        // head entry fields
  logic            pop;         // commit frees the head
  predict_update_t predict_upd; // commit-time training

  completion_buffer i_cb (
    .CLK        (CLK),
    .nRST       (nRST),
    .alloc      (alloc),
    .alloc_rec  (alloc_rec),
    .full       (full),
    .alloc_tag  (alloc_tag),
    .wb_valid   (wb_valid),
    .wb_rec     (wb_rec),
    .pop        (pop),
    .head_valid (head_valid),
    .head       (head)
  );

  commit_stage i_commit (
    .CLK             (CLK),
    .nRST            (nRST),
    .halt            (halt),
    .stall           (stall),
    .head_valid      (head_valid),
    .head            (head),
    .pop             (pop),
    .retire          (retire),
    .retire_pc       (retire_pc),
    .predict_upd     (predict_upd),
    .fault           (fault),
    .mispredict      (mispredict),
    .latest_valid_pc (latest_valid_pc)
  );

  branch_history_table i_bht (
    .CLK           (CLK),
    .nRST          (nRST),
    .predict_upd   (predict_upd),
    .lookup_pc     (lookup_pc),
    .predict_taken (predict_taken)
  );

endmodule

`default_nettype wire

/* design/commit_types_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Commit path microarchitecture types
// completion buffer sizing, dispatch and writeback records, the stored slot,
// the head view seen by commit, and predictor / fault report records
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package commit_types_pkg;

  // completion buffer sizing
  localparam int CB_DEPTH = 8;         // instructions in flight
  localparam int TAG_W    = 3;         // log2(CB_DEPTH)
  localparam int CNT_W    = TAG_W + 1; // occupancy count, 0..CB_DEPTH

  typedef logic [TAG_W-1:0] cb_tag_t;  // slot index handed out at dispatch

  // branch history table sizing
  localparam int BHT_ENTRIES = 16;
  localparam int BHT_IDX_W   = 4;
  localparam int BHT_IDX_LSB = 2;      // index is pc[5:2], word aligned

  // 2-bit counter states
  localparam logic [1:0] CTR_MIN     = 2'b00; // strongly not-taken
  localparam logic [1:0] CTR_WEAK_NT = 2'b01; // reset state
  localparam logic [1:0] CTR_MAX     = 2'b11; // strongly taken

  // dispatch side, written at allocation (41 bits)
  typedef struct packed {
    rv32_types_pkg::pc_t     pc;
    rv32_types_pkg::opcode_t opcode;
    logic                    branch_instr;
    logic                    prediction;   // predicted taken at fetch
  } dispatch_rec_t;

  // execute side, written back by tag (37 bits)
  typedef struct packed {
    cb_tag_t                 tag;
    logic                    branch_taken;
    rv32_types_pkg::pc_t     br_resolved_addr;
    logic                    fault_insn;
  } wb_rec_t;

  // one stored buffer slot
  typedef struct packed {
    dispatch_rec_t           disp;
    logic                    branch_taken;
    rv32_types_pkg::pc_t     br_resolved_addr;
    logic                    fault_insn;
    logic                    done;         // result has been written back
  } cb_entry_t;

  // head entry as presented to the commit stage
  typedef struct packed {
    rv32_types_pkg::pc_t     pc;
    rv32_types_pkg::opcode_t opcode;
    logic                    branch_instr;
    logic                    prediction;
    logic                    branch_taken;
    rv32_types_pkg::pc_t     br_resolved_addr;
    logic                    fault_insn;
  } commit_rec_t;

  // commit-time predictor training
  typedef struct packed {
    logic                    update_predictor;
    rv32_types_pkg::pc_t     update_addr;   // pc of the retiring branch
    logic                    branch_result; // resolved direction
    logic                    prediction;
  } predict_update_t;

  // instruction fault report
  typedef struct packed {
    logic                    fault_insn;
    rv32_types_pkg::pc_t     badaddr_i;
  } fault_rep_t;

endpackage

`default_nettype wire

/* design/completion_buffer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Completion buffer
// circular in-order buffer: dispatch allocates at the tail, execute units
// write results back by tag in any order, commit pops the done head entry
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module completion_buffer (
  input  logic                            CLK,
  input  logic                            nRST,
  // dispatch
  input  logic                            alloc,
  input  commit_types_pkg::dispatch_rec_t alloc_rec,
  output logic                            full,
  output commit_types_pkg::cb_tag_t       alloc_tag,
  // writeback
  input  logic                            wb_valid,
  input  commit_types_pkg::wb_rec_t       wb_rec,
  // commit
  input  logic                            pop,
  output logic                            head_valid,
  output commit_types_pkg::commit_rec_t   head
);

  import commit_types_pkg::*;

  cb_entry_t        slots [CB_DEPTH]; // entry storage, no reset
  cb_entry_t        head_slot;        // slot under the head pointer
  cb_tag_t          head_ptr;         // oldest instruction
  cb_tag_t          tail_ptr;         // next slot to allocate
  logic [CNT_W-1:0] count;            // occupied slots
  logic             occupied;
  logic             do_alloc;
  logic             do_pop;

  assign full      = (count == CNT_W'(CB_DEPTH));
  assign alloc_tag = tail_ptr;             // valid in the alloc cycle
  assign do_alloc  = alloc & ~full;        // alloc against full is dropped
  assign occupied  = (count != '0);
  assign do_pop    = pop & head_valid;     // guard against a stray pop

  // pointers and occupancy
  // depth is a power of two so the pointers wrap on their own
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (do_alloc)
        tail_ptr <= tail_ptr + 1'b1;
      if (do_pop)
        head_ptr <= head_ptr + 1'b1; // slot frees at this edge
      case ({do_alloc, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // none, or one in and one out
      endcase
    end
  end

  // slot writes
  // an allocation and a writeback never land on the same slot: the tail is
  // free while a writeback names an allocated tag
  always_ff @(posedge CLK) begin
    if (do_alloc) begin
      slots[tail_ptr].disp <= alloc_rec;
      slots[tail_ptr].done <= 1'b0;  // result not back yet
    end
    if (wb_valid) begin
      slots[wb_rec.tag].branch_taken     <= wb_rec.branch_taken;
      slots[wb_rec.tag].br_resolved_addr <= wb_rec.br_resolved_addr;
      slots[wb_rec.tag].fault_insn       <= wb_rec.fault_insn;
      slots[wb_rec.tag].done             <= 1'b1;
    end
  end

  // head view
  assign head_slot  = slots[head_ptr];
  // stale done bits in free slots are masked by the occupancy check
  assign head_valid = occupied & head_slot.done;

  assign head.pc               = head_slot.disp.pc;
  assign head.opcode           = head_slot.disp.opcode;
  assign head.branch_instr     = head_slot.disp.branch_instr;
  assign head.prediction       = head_slot.disp.prediction;
  assign head.branch_taken     = head_slot.branch_taken;
  assign head.br_resolved_addr = head_slot.br_resolved_addr;
  assign head.fault_insn       = head_slot.fault_insn;

endmodule

`default_nettype wire

/* design/rv32_types_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32 ISA-level types
// data words, instruction addresses and major opcodes used by every block
// of the commit path
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package rv32_types_pkg;

  // architectural widths
  localparam int XLEN  = 32;  // RV32 register and address width
  localparam int OPC_W = 7;   // major opcode field, instr[6:0]

  // basic ISA types
  typedef logic [XLEN-1:0]  word_t;   // data word
  typedef logic [XLEN-1:0]  pc_t;     // instruction address
  typedef logic [OPC_W-1:0] opcode_t; // major opcode

  // major opcodes
  // an all-zero opcode is never a legal RV32 encoding, so the pipeline
  // uses it to mark a bubble slot
  localparam opcode_t OPC_BUBBLE = 7'b0000000;
  localparam opcode_t OPC_BRANCH = 7'b1100011; // beq/bne/blt/bge/bltu/bgeu
  localparam opcode_t OPC_OP     = 7'b0110011; // reg-reg alu ops

endpackage

`default_nettype wire

/* list.f */
design/rv32_types_pkg.sv
design/commit_types_pkg.sv
design/completion_buffer.sv
design/commit_stage.sv
design/branch_history_table.sv
design/commit_subsystem.sv
test/commit_subsystem_tb.sv

/* test/commit_subsystem_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Commit subsystem testbench
// table-driven allocate, writeback and retire rounds checked every cycle
// against a model of retire order, branch counters and the latest valid pc
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module commit_subsystem_tb;

  import rv32_types_pkg::*;
  import commit_types_pkg::*;

  localparam int         NROWS      = 24;
  localparam int         GROUP      = CB_DEPTH;  // rows per round fill the buffer
  localparam int         ROW_BOUND  = 8;         // cycles allowed per row
  localparam int         MAX_CYCLES = NROWS * ROW_BOUND + 64;
  localparam logic [3:0] RANK_RAND  = 4'hf;      // writeback rank drawn from lfsr
  localparam logic [2:0] GRP_STALL  = 3'b010;    // round 1 runs with stall high

  typedef struct packed {
    pc_t        pc;
    opcode_t    opcode;
    logic       br;
    logic       pred;
    logic       taken;
    logic       flt;
    logic [3:0] rank;  // writeback order inside the round
  } row_t;

  // pc, opcode, branch, prediction, taken, fault, writeback rank
  localparam row_t TBL [NROWS] = '{
    '{32'h1000, OPC_OP,     1'b0, 1'b0, 1'b0, 1'b0, 4'd3},
    '{32'h1004, OPC_BRANCH, 1'b1, 1'b0, 1'b1, 1'b0, 4'd1},  // mispredict
    '{32'h1008, 7'd0,       1'b0, 1'b0, 1'b0, 1'b0, 4'd7},  // bubble
    '{32'h100c, OPC_OP,     1'b0, 1'b0, 1'b0, 1'b1, 4'd0},  // fault
    '{32'h1010, OPC_BRANCH, 1'b1, 1'b0, 1'b1, 1'b0, 4'd5},
    '{32'h1014, OPC_OP,     1'b0, 1'b0, 1'b1, 1'b0, 4'd2},  // taken bit on a non-branch
    '{32'h1010, OPC_BRANCH, 1'b1, 1'b1, 1'b1, 1'b0, 4'd6},
    '{32'h1018, 7'd0,       1'b0, 1'b0, 1'b0, 1'b0, 4'd4},
    '{32'h1020, OPC_BRANCH, 1'b1, 1'b0, 1'b0, 1'b0, RANK_RAND},
    '{32'h1010, OPC_BRANCH, 1'b1, 1'b1, 1'b1, 1'b0, RANK_RAND},  // saturates at 11
    '{32'h1024, OPC_OP,     1'b0, 1'b0, 1'b0, 1'b1, RANK_RAND},
    '{32'h1010, OPC_BRANCH, 1'b1, 1'b1, 1'b0, 1'b0, RANK_RAND},
    '{32'h1028, OPC_OP,     1'b0, 1'b0, 1'b0, 1'b0, RANK_RAND},
    '{32'h102c, 7'd0,       1'b0, 1'b0, 1'b0, 1'b0, RANK_RAND},
    '{32'h1004, OPC_BRANCH, 1'b1, 1'b1, 1'b0, 1'b0, RANK_RAND},
    '{32'h1030, OPC_OP,     1'b0, 1'b0, 1'b0, 1'b0, RANK_RAND},
    '{32'h1034, OPC_BRANCH, 1'b1, 1'b0, 1'b0, 1'b0, 4'd7},
    '{32'h1034, OPC_BRANCH, 1'b1, 1'b0, 1'b0, 1'b0, 4'd6},  // saturates at 00
    '{32'h1038, OPC_OP,     1'b0, 1'b0, 1'b0, 1'b1, 4'd5},
    '{32'h1010, OPC_BRANCH, 1'b1, 1'b1, 1'b0, 1'b0, 4'd4},
    '{32'h103c, OPC_BRANCH, 1'b1, 1'b0, 1'b1, 1'b0, 4'd3},
    '{32'h1040, OPC_OP,     1'b0, 1'b0, 1'b0, 1'b0, 4'd2},  // last real insn
    '{32'h1044, 7'd0,       1'b0, 1'b0, 1'b0, 1'b0, 4'd1},
    '{32'h1048, 7'd0,       1'b0, 1'b0, 1'b0, 1'b0, 4'd0}
  };

  logic          CLK;
  logic          nRST;
  logic          alloc;
  dispatch_rec_t alloc_rec;
  logic          full;
  cb_tag_t       alloc_tag;
  logic          wb_valid;
  wb_rec_t       wb_rec;
  logic          stall;
  logic          halt;
  logic          retire;
  pc_t           retire_pc;
  fault_rep_t    fault;
  logic          mispredict;
  pc_t           latest_valid_pc;
  pc_t           lookup_pc;
  logic          predict_taken;

  // reference model
  int            m_row [CB_DEPTH];     // table row held in each slot
  logic          m_done [CB_DEPTH];
  int            m_head;
  int            m_tail;
  int            m_count;
  logic [1:0]    m_ctr [BHT_ENTRIES];
  pc_t           m_lvpc;
  pc_t           m_last_pc;            // pc of the last retire drives lookup
  int            row_tag [NROWS];
  int            cur_row;              // row being allocated or -1 for a dummy
  int            dut_retires;
  int            cycles;
  logic [31:0]   lfsr;

  commit_subsystem i_dut (.*);

  always #4 CLK = ~CLK;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] act,
                           input logic [31:0] exp);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s: got 0x%h expected 0x%h", name, act, exp));
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // check outputs mid-cycle and advance the model before stepping past the edge
  task automatic tick();
    logic       exp_ret;
    logic       exp_full;
    logic [3:0] idx;
    int         r;
    @(negedge CLK);
    exp_full = (m_count == CB_DEPTH);
    exp_ret  = (m_count != 0) && m_done[m_head] && !stall;
    r        = m_row[m_head];
    idx      = TBL[r].pc[5:2];
    if (retire)
      dut_retires++;
    check_val("full", 32'(full), 32'(exp_full));
    check_val("retire", 32'(retire), 32'(exp_ret));
    check_val("latest_valid_pc", latest_valid_pc, m_lvpc);
    check_val("predict_taken", 32'(predict_taken), 32'(m_ctr[lookup_pc[5:2]][1]));
    if (alloc)
      check_val("alloc_tag", 32'(alloc_tag), 32'(m_tail));
    if (exp_ret) begin
      check_val("retire_pc", retire_pc, TBL[r].pc);
      check_val("mispredict", 32'(mispredict),
                32'(TBL[r].br && (TBL[r].pred != TBL[r].taken)));
      check_val("fault_insn", 32'(fault.fault_insn), 32'(TBL[r].flt));
      if (TBL[r].flt)
        check_val("badaddr_i", fault.badaddr_i, TBL[r].pc);
    end else begin
      check_val("mispredict", 32'(mispredict), 32'h0);
      check_val("fault_insn", 32'(fault.fault_insn), 32'h0);
    end
    if (halt)
      m_lvpc = '0;                               // halt beats a retire
    else if (exp_ret && TBL[r].opcode != 7'd0)
      m_lvpc = TBL[r].pc;                        // bubbles leave it alone
    if (exp_ret && TBL[r].br) begin
      if (TBL[r].taken && m_ctr[idx] != 2'b11)
        m_ctr[idx] = m_ctr[idx] + 2'd1;
      else if (!TBL[r].taken && m_ctr[idx] != 2'b00)
        m_ctr[idx] = m_ctr[idx] - 2'd1;
    end
    if (exp_ret) begin
      m_last_pc = TBL[r].pc;
      m_head    = (m_head + 1) % CB_DEPTH;
      m_count--;
    end
    if (wb_valid)
      m_done[wb_rec.tag] = 1'b1;
    if (alloc && !exp_full) begin
      m_row[m_tail]    = cur_row;
      m_done[m_tail]   = 1'b0;
      row_tag[cur_row] = m_tail;
      m_tail           = (m_tail + 1) % CB_DEPTH;
      m_count++;
    end
    @(posedge CLK);
    #1;
    alloc     = 1'b0;
    wb_valid  = 1'b0;
    halt      = 1'b0;
    lookup_pc = m_last_pc;  // look at the branch that just trained
  endtask

  // run limit
  always @(posedge CLK) begin
    cycles++;
    if (cycles > MAX_CYCLES)
      fail_run("timeout: the table did not finish within the cycle limit");
  end

  initial begin
    int base;
    int rk [GROUP];
    CLK         = 1'b0;
    nRST        = 1'b0;
    alloc       = 1'b0;
    alloc_rec   = '0;
    wb_valid    = 1'b0;
    wb_rec      = '0;
    stall       = 1'b0;
    halt        = 1'b0;
    lookup_pc   = '0;
    lfsr        = 32'hf336;
    m_head      = 0;
    m_tail      = 0;
    m_count     = 0;
    m_lvpc      = '0;
    m_last_pc   = '0;
    dut_retires = 0;
    cycles      = 0;
    for (int i = 0; i < CB_DEPTH; i++) begin
      m_row[i]  = 0;
      m_done[i] = 1'b0;
    end
    for (int i = 0; i < BHT_ENTRIES; i++)
      m_ctr[i] = 2'b01;                          // weakly not-taken
    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;

    // sweep every table index in the reset state
    for (int i = 0; i < BHT_ENTRIES; i++) begin
      lookup_pc = pc_t'(i << 2);
      tick();
    end

    for (int g = 0; g < NROWS / GROUP; g++) begin
      base  = g * GROUP;
      stall = GRP_STALL[g];
      for (int i = 0; i < GROUP; i++) begin
        cur_row                = base + i;
        alloc                  = 1'b1;
        alloc_rec.pc           = TBL[base+i].pc;
        alloc_rec.opcode       = TBL[base+i].opcode;
        alloc_rec.branch_instr = TBL[base+i].br;
        alloc_rec.prediction   = TBL[base+i].pred;
        tick();
      end
      // the buffer is full so this one must be dropped
      cur_row          = -1;
      alloc            = 1'b1;
      alloc_rec.pc     = 32'hdead_beef;
      alloc_rec.opcode = OPC_OP;
      tick();
      for (int i = 0; i < GROUP; i++) begin
        rk[i] = int'(TBL[base+i].rank);
        if (TBL[base+i].rank == RANK_RAND) begin
          rk[i] = 0;
          repeat (3) rk[i] = rk[i] * 2 + int'(lfsr_bit());
        end
      end
      // writebacks go in rank order with ties broken by row
      for (int r = 0; r < 16; r++) begin
        for (int i = 0; i < GROUP; i++) begin
          if (rk[i] == r) begin
            wb_valid                = 1'b1;
            wb_rec.tag              = cb_tag_t'(row_tag[base+i]);
            wb_rec.branch_taken     = TBL[base+i].taken;
            wb_rec.br_resolved_addr = TBL[base+i].pc + 32'd8;
            wb_rec.fault_insn       = TBL[base+i].flt;
            tick();
          end
        end
      end
      repeat (3) tick();   // under stall the done head must stay put
      stall = 1'b0;
      while (m_count != 0)
        tick();
    end

    check_val("retire_count", dut_retires, NROWS);
    check_val("latest_valid_pc", latest_valid_pc, TBL[21].pc);
    halt = 1'b1;
    tick();
    check_val("latest_valid_pc", latest_valid_pc, 32'h0);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire
